/* design/estPkg.sv */
`default_nettype none

package estPkg;

    // Modulator control vector
    localparam int SampleBits = 4;
    typedef logic [SampleBits-1:0] SampleT;

    // Batch geometry and the sample ring
    localparam int BatchLen = 16;
    typedef logic [$clog2(BatchLen)-1:0] PosT;
    localparam int SlotCount = 4;
    typedef logic [$clog2(SlotCount)-1:0] SlotT;

    // Cycles from a buffer read address to the matching filter state
    localparam int PipeLag = 2;

    // Recursion state, signed fixed point
    localparam int StateBits = 24;
    typedef logic signed [StateBits-1:0] StateT;

    // One signed input weight per control bit
    localparam int WeightBits = 16;
    typedef logic signed [WeightBits-1:0] WeightT;
    localparam WeightT Gamma [SampleBits] = '{
        16'sd4000, 16'sd3000, 16'sd2000, 16'sd1000
    };

    // Leak of the recursion, as a right shift
    localparam int LeakShift = 3;

    // Estimate format
    localparam int OutBits = 14;
    typedef logic [OutBits-1:0] OutT;
    localparam int OutShift = 4;
    localparam int OutMax = 2 ** (OutBits - 1) - 1;
    localparam int OutMin = -(2 ** (OutBits - 1));

    // Pipeline fill tracking
    typedef enum logic [1:0] {PhaseFill, PhasePrime, PhaseRun} PhaseT;

endpackage

`default_nettype wire

/* design/batchSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module batchSequencer (
    input  logic         clkDS,
    input  logic         rst,
    output estPkg::PosT  pos,
    output logic         batchEnd,
    output estPkg::SlotT writeSlot,
    output estPkg::SlotT lookSlot,
    output estPkg::SlotT calcSlot,
    output logic         estimateValid
);

    estPkg::PhaseT phase;

    // Last position of the current batch
    assign batchEnd = (pos == estPkg::PosT'(estPkg::BatchLen - 1));

    // Lookahead trails the write slot by one batch
    assign lookSlot = writeSlot - estPkg::SlotT'(1);

    // Oldest slot; the idle slot between holds the batch that seeds it
    assign calcSlot = writeSlot - estPkg::SlotT'(estPkg::SlotCount - 1);

    // Position and slot rotation
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            pos       <= '0;
            writeSlot <= '0;
        end else begin
            pos <= pos + estPkg::PosT'(1);
            if (batchEnd) begin
                writeSlot <= writeSlot + estPkg::SlotT'(1);
            end
        end
    end

    // Fill tracking until the first batch reaches the output
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            phase <= estPkg::PhaseFill;
        end else begin
            case (phase)
                estPkg::PhaseFill: begin
                    // all slots written once, first batch now combined
                    if (batchEnd && writeSlot == estPkg::SlotT'(estPkg::SlotCount - 1)) begin
                        phase <= estPkg::PhasePrime;
                    end
                end
                estPkg::PhasePrime: begin
                    if (batchEnd) begin
                        phase <= estPkg::PhaseRun;
                    end
                end
                estPkg::PhaseRun: begin
                    phase <= estPkg::PhaseRun;
                end
                default: begin
                    phase <= estPkg::PhaseFill;
                end
            endcase
        end
    end

    // First drain read of batch 0 happens at pos == PipeLag
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            estimateValid <= 1'b0;
        end else if (phase == estPkg::PhasePrime && pos == estPkg::PosT'(estPkg::PipeLag)) begin
            estimateValid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/sampleBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module sampleBuffer (
    input  logic           clkDS,
    input  logic           rst,
    input  estPkg::SampleT sample,
    input  estPkg::PosT    pos,
    input  estPkg::SlotT   writeSlot,
    input  estPkg::SlotT   lookSlot,
    input  estPkg::SlotT   calcSlot,
    output estPkg::SampleT lookSample,
    output estPkg::SampleT fwdSample,
    output estPkg::SampleT bwdSample
);

    // Ring of four batches
    estPkg::SampleT mem [estPkg::SlotCount][estPkg::BatchLen];

    // Position walked from the end of the batch
    estPkg::PosT revPos;

    assign revPos = estPkg::PosT'(estPkg::BatchLen - 1) - pos;

    // One sample per cycle into the write slot
    always_ff @(posedge clkDS) begin
        mem[writeSlot][pos] <= sample;
    end

    // Three registered reads, one cycle after the address
    // The write slot never equals a read slot, so no bypass is needed
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            lookSample <= '0;
            fwdSample  <= '0;
            bwdSample  <= '0;
        end else begin
            // Lookahead batch in reverse
            lookSample <= mem[lookSlot][revPos];
            // Batch under computation, both directions
            fwdSample  <= mem[calcSlot][pos];
            bwdSample  <= mem[calcSlot][revPos];
        end
    end

endmodule

`default_nettype wire

/* design/forwardFilter.sv */
`timescale 1ns/10ps
`default_nettype none

module forwardFilter (
    input  logic           clkDS,
    input  logic           rst,
    input  estPkg::SampleT fwdSample,
    input  estPkg::PosT    pos,
    output estPkg::StateT  fwdState,
    output estPkg::PosT    fwdPos
);

    estPkg::PosT  dPos;
    estPkg::SlotT batchesSeen;
    logic         live;

    // Signed weight of one control vector
    function automatic estPkg::StateT weight(input estPkg::SampleT s);
        estPkg::StateT acc;
        acc = '0;
        for (int k = 0; k < estPkg::SampleBits; k++) begin
            if (s[k]) begin
                acc = acc + estPkg::StateT'(estPkg::Gamma[k]);
            end else begin
                acc = acc - estPkg::StateT'(estPkg::Gamma[k]);
            end
        end
        return acc;
    endfunction

    // The calc slot holds real samples only once the ring is filled
    assign live = (batchesSeen == estPkg::SlotT'(estPkg::SlotCount - 1));

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            dPos        <= '0;
            fwdPos      <= '0;
            batchesSeen <= '0;
            fwdState    <= '0;
        end else begin
            // Align position with the registered buffer read
            dPos   <= pos;
            fwdPos <= dPos;
            if (live) begin
                // Leaky step, state carried across batches
                fwdState <= fwdState - (fwdState >>> estPkg::LeakShift) + weight(fwdSample);
            end else if (dPos == estPkg::PosT'(estPkg::BatchLen - 1)) begin
                batchesSeen <= batchesSeen + estPkg::SlotT'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* design/backwardFilter.sv */
`timescale 1ns/10ps
`default_nettype none

module backwardFilter (
    input  logic           clkDS,
    input  logic           rst,
    input  estPkg::SampleT lookSample,
    input  estPkg::SampleT bwdSample,
    input  estPkg::PosT    pos,
    input  logic           batchEnd,
    output estPkg::StateT  bwdState,
    output estPkg::PosT    bwdPos
);

    estPkg::PosT   dPos;
    logic          lastRev;
    estPkg::StateT lookState;
    estPkg::StateT seed;
    estPkg::StateT lookNext;
    estPkg::StateT bwdBase;
    estPkg::StateT bwdNext;

    // Signed weight of one control vector
    function automatic estPkg::StateT weight(input estPkg::SampleT s);
        estPkg::StateT acc;
        acc = '0;
        for (int k = 0; k < estPkg::SampleBits; k++) begin
            if (s[k]) begin
                acc = acc + estPkg::StateT'(estPkg::Gamma[k]);
            end else begin
                acc = acc - estPkg::StateT'(estPkg::Gamma[k]);
            end
        end
        return acc;
    endfunction

    function automatic estPkg::StateT step(input estPkg::StateT state, input estPkg::SampleT s);
        return state - (state >>> estPkg::LeakShift) + weight(s);
    endfunction

    // Lookahead over the newer batch, always from its cleared state
    assign lookNext = step(lookState, lookSample);

    // First reversed sample starts from the seed of the newer batch
    assign bwdBase = (dPos == '0) ? seed : bwdState;
    assign bwdNext = step(bwdBase, bwdSample);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            dPos      <= '0;
            lastRev   <= 1'b0;
            lookState <= '0;
            seed      <= '0;
            bwdState  <= '0;
            bwdPos    <= '0;
        end else begin
            // Delay matches the registered buffer read
            dPos    <= pos;
            lastRev <= batchEnd;
            // Reverse walk, so the tag counts down
            bwdState <= bwdNext;
            bwdPos   <= estPkg::PosT'(estPkg::BatchLen - 1) - dPos;
            if (lastRev) begin
                // sample 0 just folded in, lookahead is complete
                seed      <= lookNext;
                lookState <= '0;
            end else begin
                lookState <= lookNext;
            end
        end
    end

endmodule

`default_nettype wire

/* design/resultCombiner.sv */
`timescale 1ns/10ps
`default_nettype none

module resultCombiner (
    input  logic          clkDS,
    input  logic          rst,
    input  estPkg::StateT fwdState,
    input  estPkg::PosT   fwdPos,
    input  estPkg::StateT bwdState,
    input  estPkg::PosT   bwdPos,
    input  estPkg::PosT   pos,
    input  logic          batchEnd,
    output estPkg::OutT   estimate
);

    // Two banks per direction, one filling while the other drains
    estPkg::StateT fwdBank [2][estPkg::BatchLen];
    estPkg::StateT bwdBank [2][estPkg::BatchLen];

    logic                         fillSel;
    logic                         drainSel;
    logic [estPkg::PipeLag-1:0]   endDly;
    estPkg::PosT                  rdPos;
    logic signed [estPkg::StateBits:0] sum;
    logic signed [estPkg::StateBits:0] scaled;
    estPkg::OutT                  clipped;

    assign drainSel = ~fillSel;

    // Partial results trail the batch counter by PipeLag cycles
    assign rdPos = pos - estPkg::PosT'(estPkg::PipeLag);

    always_ff @(posedge clkDS) begin
        fwdBank[fillSel][fwdPos] <= fwdState;
        bwdBank[fillSel][bwdPos] <= bwdState;
    end

    // Swap once the last partial result of the batch is stored
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            endDly  <= '0;
            fillSel <= 1'b0;
        end else begin
            endDly <= {endDly[estPkg::PipeLag-2:0], batchEnd};
            if (endDly[estPkg::PipeLag-1]) begin
                fillSel <= ~fillSel;
            end
        end
    end

    // Combine in time order from the drain bank
    assign sum    = fwdBank[drainSel][rdPos] + bwdBank[drainSel][rdPos];
    assign scaled = sum >>> estPkg::OutShift;

    always_comb begin
        if (scaled > estPkg::OutMax) begin
            clipped = estPkg::OutT'(estPkg::OutMax);
        end else if (scaled < estPkg::OutMin) begin
            clipped = estPkg::OutT'(estPkg::OutMin);
        end else begin
            clipped = estPkg::OutT'(scaled);
        end
    end

    // Offset binary out
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            estimate <= '0;
        end else begin
            estimate <= {~clipped[estPkg::OutBits-1], clipped[estPkg::OutBits-2:0]};
        end
    end

endmodule

`default_nettype wire

/* design/batchEstimator.sv */
`timescale 1ns/10ps
`default_nettype none

module batchEstimator (
    input  logic           clkDS,
    input  logic           rst,
    input  estPkg::SampleT sample,
    output estPkg::OutT    estimate,
    output logic           estimateValid
);

    estPkg::PosT    pos;
    logic           batchEnd;
    estPkg::SlotT   writeSlot;
    estPkg::SlotT   lookSlot;
    estPkg::SlotT   calcSlot;
    estPkg::SampleT lookSample;
    estPkg::SampleT fwdSample;
    estPkg::SampleT bwdSample;
    estPkg::StateT  fwdState;
    estPkg::PosT    fwdPos;
    estPkg::StateT  bwdState;
    estPkg::PosT    bwdPos;

    batchSequencer batchSequencer_i (
        .clkDS         (clkDS),
        .rst           (rst),
        .pos           (pos),
        .batchEnd      (batchEnd),
        .writeSlot     (writeSlot),
        .lookSlot      (lookSlot),
        .calcSlot      (calcSlot),
        .estimateValid (estimateValid)
    );

    sampleBuffer sampleBuffer_i (
        .clkDS      (clkDS),
        .rst        (rst),
        .sample     (sample),
        .pos        (pos),
        .writeSlot  (writeSlot),
        .lookSlot   (lookSlot),
        .calcSlot   (calcSlot),
        .lookSample (lookSample),
        .fwdSample  (fwdSample),
        .bwdSample  (bwdSample)
    );

    // Forward and backward directions run side by side
    forwardFilter forwardFilter_i (
        .clkDS     (clkDS),
        .rst       (rst),
        .fwdSample (fwdSample),
        .pos       (pos),
        .fwdState  (fwdState),
        .fwdPos    (fwdPos)
    );

    backwardFilter backwardFilter_i (
        .clkDS      (clkDS),
        .rst        (rst),
        .lookSample (lookSample),
        .bwdSample  (bwdSample),
        .pos        (pos),
        .batchEnd   (batchEnd),
        .bwdState   (bwdState),
        .bwdPos     (bwdPos)
    );

    resultCombiner resultCombiner_i (
        .clkDS    (clkDS),
        .rst      (rst),
        .fwdState (fwdState),
        .fwdPos   (fwdPos),
        .bwdState (bwdState),
        .bwdPos   (bwdPos),
        .pos      (pos),
        .batchEnd (batchEnd),
        .estimate (estimate)
    );

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clkDS
);

    // 100 ns period
    localparam int HalfPeriodNs = 50;

    initial begin
        clkDS = 1'b0;
        forever begin
            #(HalfPeriodNs) clkDS = ~clkDS;
        end
    end

endmodule

`default_nettype wire

/* test/tbBatchEstimator.sv */
`timescale 1ns/10ps
`default_nettype none

module tbBatchEstimator;

    localparam int NumBatches = 12;
    localparam int NumRuns = 2;
    localparam logic [31:0] Seed = 32'hee20_9741;
    localparam int ClkPeriodNs = 100;
    localparam int TopCode = 2 ** estPkg::OutBits - 1;

    logic           clkDS;
    logic           rst;
    estPkg::SampleT sample;
    estPkg::OutT    estimate;
    logic           estimateValid;

    estPkg::SampleT stimQ [$];
    estPkg::OutT    expectQ [$];
    logic [31:0]    lfsrState;
    int             checkIdx = 0;
    int             checkedCount = 0;
    bit             seenValid = 1'b0;
    int             topCount = 0;
    int             bottomCount = 0;

    clockGen clockGen_i (
        .clkDS (clkDS)
    );

    batchEstimator batchEstimator_i (
        .clkDS         (clkDS),
        .rst           (rst),
        .sample        (sample),
        .estimate      (estimate),
        .estimateValid (estimateValid)
    );

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Galois LFSR
    // Output bit is the LSB before the shift
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic estPkg::SampleT randomSample();
        estPkg::SampleT s;
        for (int k = 0; k < estPkg::SampleBits; k++) begin
            s[k] = lfsrState[0];
            lfsrState = lfsrStep(lfsrState);
        end
        return s;
    endfunction

    // Plus Gamma for each set bit, minus Gamma for each clear bit
    function automatic int inputWeight(input estPkg::SampleT s);
        int w;
        w = 0;
        for (int k = 0; k < estPkg::SampleBits; k++) begin
            w += s[k] ? int'(estPkg::Gamma[k]) : -int'(estPkg::Gamma[k]);
        end
        return w;
    endfunction

    function automatic int leakStep(input int state, input estPkg::SampleT s);
        return state - (state >>> estPkg::LeakShift) + inputWeight(s);
    endfunction

    // Saturating runs of ones and zeros with random batches elsewhere
    task automatic fillStimulus(input int run);
        int onesFirst;
        int zerosFirst;
        estPkg::SampleT s;
        onesFirst = (run == 0) ? 3 : 6;
        zerosFirst = (run == 0) ? 6 : 2;
        stimQ.delete();
        for (int b = 0; b < NumBatches; b++) begin
            for (int n = 0; n < estPkg::BatchLen; n++) begin
                if (run == 0 && b == 0) begin
                    s = '1;
                end else if (b >= onesFirst && b < onesFirst + 3) begin
                    s = '1;
                end else if (b >= zerosFirst && b < zerosFirst + 3) begin
                    s = '0;
                end else begin
                    s = randomSample();
                end
                stimQ.push_back(s);
            end
        end
    endtask

    // Expected stream for every batch that has a following batch
    function automatic void computeReference();
        int fwd;
        int look;
        int bwd;
        int scaled;
        int fwdVals [estPkg::BatchLen];
        int bwdVals [estPkg::BatchLen];
        expectQ.delete();
        fwd = 0;
        for (int b = 0; b < NumBatches - 1; b++) begin
            for (int n = 0; n < estPkg::BatchLen; n++) begin
                fwd = leakStep(fwd, stimQ[b * estPkg::BatchLen + n]);
                fwdVals[n] = fwd;
            end
            look = 0;
            for (int n = estPkg::BatchLen - 1; n >= 0; n--) begin
                look = leakStep(look, stimQ[(b + 1) * estPkg::BatchLen + n]);
            end
            // Backward pass seeded by the lookahead
            bwd = look;
            for (int n = estPkg::BatchLen - 1; n >= 0; n--) begin
                bwd = leakStep(bwd, stimQ[b * estPkg::BatchLen + n]);
                bwdVals[n] = bwd;
            end
            for (int n = 0; n < estPkg::BatchLen; n++) begin
                scaled = (fwdVals[n] + bwdVals[n]) >>> estPkg::OutShift;
                if (scaled > estPkg::OutMax) begin
                    scaled = estPkg::OutMax;
                end else if (scaled < estPkg::OutMin) begin
                    scaled = estPkg::OutMin;
                end
                expectQ.push_back(estPkg::OutT'(scaled + 2 ** (estPkg::OutBits - 1)));
            end
        end
    endfunction

    // Outputs are sampled mid-cycle
    always @(negedge clkDS) begin
        if (!rst) begin
            checkValue(32'(estimateValid), 32'd0, "estimateValid during reset");
            checkValue(32'(estimate), 32'd0, "estimate during reset");
            checkIdx = 0;
            checkedCount = 0;
            seenValid = 1'b0;
        end else begin
            if (seenValid) begin
                checkValue(32'(estimateValid), 32'd1, "estimateValid dropped");
            end
            if (estimateValid) begin
                seenValid = 1'b1;
                if (checkIdx < expectQ.size()) begin
                    checkValue(32'(estimate), 32'(expectQ[checkIdx]),
                               $sformatf("estimate %0d of the run", checkIdx));
                    if (estimate == estPkg::OutT'(TopCode)) begin
                        topCount++;
                    end
                    if (estimate == '0) begin
                        bottomCount++;
                    end
                    checkIdx++;
                    checkedCount = checkIdx;
                end
            end
        end
    end

    initial begin
        rst <= 1'b0;
        sample <= '0;
        lfsrState = Seed;
        for (int run = 0; run < NumRuns; run++) begin
            if (run > 0) begin
                // Reset again while the stream is still running
                @(posedge clkDS);
                rst <= 1'b0;
            end
            fillStimulus(run);
            computeReference();
            repeat (2) @(posedge clkDS);
            rst <= 1'b1;
            sample <= stimQ[0];
            for (int i = 1; i < stimQ.size(); i++) begin
                @(posedge clkDS);
                sample <= stimQ[i];
            end
            @(posedge clkDS);
            sample <= '0;
            while (checkedCount < expectQ.size()) begin
                @(posedge clkDS);
            end
        end
        checkValue(32'(topCount > 0), 32'd1, "no estimate reached the top code");
        checkValue(32'(bottomCount > 0), 32'd1, "no estimate reached the bottom code");
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(NumRuns * (NumBatches + 4) * estPkg::BatchLen * ClkPeriodNs);
        $display("Timeout: the estimate stream did not complete in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog.f */
design/estPkg.sv
design/batchSequencer.sv
design/sampleBuffer.sv
design/forwardFilter.sv
design/backwardFilter.sv
design/resultCombiner.sv
design/batchEstimator.sv
test/clockGen.sv
test/tbBatchEstimator.sv
